//--- src.f
+incdir+design
design/usb_demo_pkg.sv
design/bulk_loopback_fifo.sv
design/uart_bit_timer.sv
design/uart_tx.sv
design/hex_dump_fsm.sv
design/usb_demo_top.sv
dv/usb_demo_checker.sv
dv/usb_demo_tb.sv

//--- Bender.yml
package:
  name: usb_demo

sources:
  - include_dirs:
      - design
    files:
      - design/usb_demo_pkg.sv
      - design/bulk_loopback_fifo.sv
      - design/uart_bit_timer.sv
      - design/uart_tx.sv
      - design/hex_dump_fsm.sv
      - design/usb_demo_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/usb_demo_checker.sv
      - dv/usb_demo_tb.sv

//--- dv/usb_demo_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "usb_demo_defs.svh"

module usb_demo_tb;

  localparam int WAIT_LIMIT = 2000;  // Clocks allowed for any one wait

  logic clock;
  logic usb_reset;
  logic configured_i;
  logic blk_store_i;
  logic blk_fetch_i;
  usb_demo_pkg::endpt_t blk_endpt_i;
  logic out_valid_i;
  usb_demo_pkg::byte_t out_data_i;
  logic out_last_i;
  logic out_ready_o;
  logic in_valid_o;
  usb_demo_pkg::byte_t in_data_o;
  logic in_last_o;
  logic in_ready_i;
  logic blk_in_ready_o;
  logic blk_out_ready_o;
  logic send_n_i;
  usb_demo_pkg::telemetry_t telemetry_i;
  logic uart_tx_o;
  logic dump_busy_o;

  integer seed;
  logic [8:0] expected_q[$];  // {last, data} still inside the FIFO
  int level;

  usb_demo_top dut (.*);

  initial clock = 1'b0;
  always #4 clock = ~clock;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else
      abort_run($sformatf("mismatch %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  task automatic check_flags(input string name);
    check_value({name, " in ready"}, configured_i && (level > `IN_READY_LEVEL), blk_in_ready_o);
    check_value({name, " out ready"}, configured_i && (level < `OUT_READY_LEVEL),
                blk_out_ready_o);
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic push_byte(input usb_demo_pkg::byte_t data, input logic last);
    int waited;
    waited = 0;
    out_valid_i = 1'b1;
    out_data_i  = data;
    out_last_i  = last;
    #1;
    while (!out_ready_o) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for out_ready_o");
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    out_valid_i = 1'b0;
    expected_q.push_back({last, data});
    level++;
  endtask

  task automatic pop_and_compare(input string name);
    int waited;
    logic done;
    logic [8:0] expected;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      in_ready_i = (($random(seed) & 3) != 0);  // Random back-pressure
      #1;
      done = in_valid_o && in_ready_i;
      if (done) begin
        expected = expected_q.pop_front();
        check_value({name, " data"}, expected[7:0], in_data_o);
        check_value({name, " last"}, expected[8], in_last_o);
      end
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for in_valid_o");
      @(negedge clock);
    end
    in_ready_i = 1'b0;
    level--;
  endtask

  // Neither stream may move for a few cycles
  task automatic expect_gated(input string name);
    repeat (4) begin
      #1;
      check_value(name, 0, {out_ready_o, in_valid_o});
      @(negedge clock);
    end
  endtask

  task automatic wait_busy(input logic value);
    int waited;
    waited = 0;
    while (dump_busy_o !== value) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for dump_busy_o");
      @(negedge clock);
    end
  endtask

  // 8N1 decoder sampling each bit in its middle
  task automatic receive_char(output usb_demo_pkg::byte_t ch);
    int waited;
    waited = 0;
    while (uart_tx_o !== 1'b0) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("no UART start bit arrived");
      @(negedge clock);
    end
    repeat (`UART_CLKS_PER_BIT / 2) @(negedge clock);
    check_value("uart start bit", 0, uart_tx_o);
    for (int i = 0; i < 8; i++) begin
      repeat (`UART_CLKS_PER_BIT) @(negedge clock);
      ch[i] = uart_tx_o;
    end
    repeat (`UART_CLKS_PER_BIT) @(negedge clock);
    check_value("uart stop bit", 1, uart_tx_o);
  endtask

  function automatic usb_demo_pkg::byte_t hex_char(input logic [3:0] value);
    if (value < 4'd10) begin
      return "0" + value;
    end
    return "a" + value - 8'd10;
  endfunction

  always @(negedge clock) begin
    if (dut.u_checker.fail_count != 0) begin
      abort_run("bound checker reported a failed assertion");
    end
  end

  initial begin
    usb_demo_pkg::byte_t data;
    usb_demo_pkg::byte_t ch;
    usb_demo_pkg::byte_t expected_ch;
    usb_demo_pkg::telemetry_t word;
    seed         = 72;
    level        = 0;
    usb_reset    = 1'b1;
    configured_i = 1'b0;
    blk_store_i  = 1'b0;
    blk_fetch_i  = 1'b0;
    blk_endpt_i  = '0;
    out_valid_i  = 1'b0;
    out_data_i   = '0;
    out_last_i   = 1'b0;
    in_ready_i   = 1'b0;
    send_n_i     = 1'b1;
    telemetry_i  = '0;
    repeat (16) @(negedge clock);
    usb_reset = 1'b0;

    check_value("reset out_ready", 0, out_ready_o);
    check_value("reset in_valid", 0, in_valid_o);
    check_value("reset flags", 0, {blk_in_ready_o, blk_out_ready_o});
    check_value("reset busy", 0, dump_busy_o);
    check_value("reset uart line", 1, uart_tx_o);

    // Loopback of one 40-byte packet
    configured_i = 1'b1;
    blk_store_i  = 1'b1;
    blk_endpt_i  = `BULK_ENDPOINT;
    for (int i = 1; i <= 40; i++) begin
      data = $random(seed);
      push_byte(data, i == 40);
    end
    blk_fetch_i = 1'b1;
    repeat (40) pop_and_compare("loopback");
    check_value("loopback empty", 0, in_valid_o);

    // Endpoint and strobe gating
    blk_fetch_i = 1'b0;
    out_valid_i = 1'b1;
    out_data_i  = 8'ha5;
    blk_endpt_i = 4'd2;
    expect_gated("store wrong endpoint");
    blk_endpt_i = `BULK_ENDPOINT;
    blk_store_i = 1'b0;
    expect_gated("store strobe low");
    out_valid_i = 1'b0;
    blk_store_i = 1'b1;
    push_byte(8'h3c, 1'b1);
    blk_store_i = 1'b0;
    expect_gated("fetch strobe low");
    blk_fetch_i = 1'b1;
    blk_endpt_i = 4'd2;
    expect_gated("fetch wrong endpoint");
    blk_endpt_i = `BULK_ENDPOINT;
    pop_and_compare("gated byte");
    check_value("gated empty", 0, in_valid_o);

    // Fill to full and drain, watching the status flags
    blk_fetch_i = 1'b0;
    blk_store_i = 1'b1;
    for (int i = 1; i <= `BULK_FIFO_DEPTH; i++) begin
      data = $random(seed);
      push_byte(data, i == `BULK_FIFO_DEPTH);
      if (i == 30) configured_i = 1'b0;
      if (i == 40) configured_i = 1'b1;
      @(negedge clock);
      check_flags($sformatf("fill %0d", i));
    end
    out_valid_i = 1'b1;
    expect_gated("full fifo");
    out_valid_i = 1'b0;
    blk_fetch_i = 1'b1;
    for (int i = 1; i <= `BULK_FIFO_DEPTH; i++) begin
      pop_and_compare("drain");
      if (i == 20) configured_i = 1'b0;
      if (i == 50) configured_i = 1'b1;
      @(negedge clock);
      check_flags($sformatf("drain %0d", i));
    end

    // Telemetry dump, snapshot must survive a change of the word
    telemetry_i = $random(seed);
    word        = telemetry_i;
    send_n_i    = 1'b0;
    wait_busy(1'b1);
    send_n_i = 1'b1;
    for (int i = 0; i < 10; i++) begin
      receive_char(ch);
      if (i == 0) telemetry_i = ~word;
      if (i < 8) begin
        expected_ch = hex_char(word[31 - 4 * i -: 4]);
      end else if (i == 8) begin
        expected_ch = `CHAR_CR;
      end else begin
        expected_ch = `CHAR_LF;
      end
      check_value($sformatf("dump char %0d", i), expected_ch, ch);
    end
    wait_busy(1'b0);

    repeat (4) @(negedge clock);
    if (dut.u_checker.fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("bound checker reported a failed assertion");
    end
  end

endmodule

`default_nettype wire

//--- dv/usb_demo_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "usb_demo_defs.svh"

module usb_demo_checker (
  input wire                   clock,
  input wire                   usb_reset,
  input wire                   configured_i,
  input wire                   blk_store_i,
  input wire                   blk_fetch_i,
  input usb_demo_pkg::endpt_t  blk_endpt_i,
  input wire                   out_valid_i,
  input wire                   out_ready_o,
  input wire                   in_valid_o,
  input wire                   in_ready_i,
  input wire                   blk_in_ready_o,
  input wire                   blk_out_ready_o,
  input wire                   uart_tx_o,
  input wire                   dump_busy_o
);

  usb_demo_pkg::level_t level_q;  // Bytes held, counted from the stream handshakes
  logic ep_match;
  logic in_flag_exp;
  logic out_flag_exp;
  int unsigned fail_count;

  assign ep_match     = (blk_endpt_i == `BULK_ENDPOINT);
  assign in_flag_exp  = configured_i && (level_q > `IN_READY_LEVEL);
  assign out_flag_exp = configured_i && (level_q < `OUT_READY_LEVEL);

  initial fail_count = 0;

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      level_q <= '0;
    end else begin
      level_q <= level_q + usb_demo_pkg::level_t'(out_valid_i && out_ready_o)
                         - usb_demo_pkg::level_t'(in_valid_o && in_ready_i);
    end
  end

  reset_quiet: assert property (@(posedge clock)
    usb_reset |=> !in_valid_o && !blk_in_ready_o && !blk_out_ready_o && !dump_busy_o
                  && uart_tx_o)
    else begin $error("outputs not in reset state"); fail_count++; end

  in_gated: assert property (@(posedge clock) disable iff (usb_reset)
    in_valid_o |-> blk_fetch_i && ep_match)
    else begin $error("in_valid_o without fetch on the bulk endpoint"); fail_count++; end

  out_gated: assert property (@(posedge clock) disable iff (usb_reset)
    out_ready_o |-> blk_store_i && ep_match)
    else begin $error("out_ready_o without store on the bulk endpoint"); fail_count++; end

  // Flags follow level and configured_i one cycle late
  flag_rule: assert property (@(posedge clock) disable iff (usb_reset)
    1'b1 |=> (blk_in_ready_o == $past(in_flag_exp)) && (blk_out_ready_o == $past(out_flag_exp)))
    else begin $error("ready flag off the level rule"); fail_count++; end

  line_idle: assert property (@(posedge clock) disable iff (usb_reset)
    !dump_busy_o |-> uart_tx_o)
    else begin $error("UART line low with no dump running"); fail_count++; end

endmodule

bind usb_demo_top usb_demo_checker u_checker (
  .clock           (clock),
  .usb_reset       (usb_reset),
  .configured_i    (configured_i),
  .blk_store_i     (blk_store_i),
  .blk_fetch_i     (blk_fetch_i),
  .blk_endpt_i     (blk_endpt_i),
  .out_valid_i     (out_valid_i),
  .out_ready_o     (out_ready_o),
  .in_valid_o      (in_valid_o),
  .in_ready_i      (in_ready_i),
  .blk_in_ready_o  (blk_in_ready_o),
  .blk_out_ready_o (blk_out_ready_o),
  .uart_tx_o       (uart_tx_o),
  .dump_busy_o     (dump_busy_o)
);

`default_nettype wire

//--- design/usb_demo_top.sv
`timescale 1ns/1ns
`default_nettype none

module usb_demo_top (
  input  wire                       clock,
  input  wire                       usb_reset,
  input  wire                       configured_i,
  input  wire                       blk_store_i,
  input  wire                       blk_fetch_i,
  input  usb_demo_pkg::endpt_t      blk_endpt_i,
  input  wire                       out_valid_i,
  input  usb_demo_pkg::byte_t       out_data_i,
  input  wire                       out_last_i,
  output logic                      out_ready_o,
  output logic                      in_valid_o,
  output usb_demo_pkg::byte_t       in_data_o,
  output logic                      in_last_o,
  input  wire                       in_ready_i,
  output logic                      blk_in_ready_o,
  output logic                      blk_out_ready_o,
  input  wire                       send_n_i,
  input  usb_demo_pkg::telemetry_t  telemetry_i,
  output logic                      uart_tx_o,
  output logic                      dump_busy_o
);

  // Telemetry path between the dumper and the UART
  logic char_valid;
  logic char_ready;
  usb_demo_pkg::byte_t char_data;
  logic timer_start;
  logic bit_tick;

  bulk_loopback_fifo u_bulk_fifo (
    .clock           (clock),
    .usb_reset       (usb_reset),
    .configured_i    (configured_i),
    .blk_store_i     (blk_store_i),
    .blk_fetch_i     (blk_fetch_i),
    .blk_endpt_i     (blk_endpt_i),
    .out_valid_i     (out_valid_i),
    .out_last_i      (out_last_i),
    .out_data_i      (out_data_i),
    .out_ready_o     (out_ready_o),
    .in_valid_o      (in_valid_o),
    .in_last_o       (in_last_o),
    .in_data_o       (in_data_o),
    .in_ready_i      (in_ready_i),
    .blk_in_ready_o  (blk_in_ready_o),
    .blk_out_ready_o (blk_out_ready_o)
  );

  hex_dump_fsm u_hex_dump (
    .clock        (clock),
    .usb_reset    (usb_reset),
    .send_n_i     (send_n_i),
    .telemetry_i  (telemetry_i),
    .char_valid_o (char_valid),
    .char_data_o  (char_data),
    .char_ready_i (char_ready),
    .dump_busy_o  (dump_busy_o)
  );

  uart_tx u_uart_tx (
    .clock         (clock),
    .usb_reset     (usb_reset),
    .char_valid_i  (char_valid),
    .char_data_i   (char_data),
    .char_ready_o  (char_ready),
    .bit_tick_i    (bit_tick),
    .timer_start_o (timer_start),
    .txd_o         (uart_tx_o)
  );

  uart_bit_timer u_bit_timer (
    .clock     (clock),
    .usb_reset (usb_reset),
    .start_i   (timer_start),
    .tick_o    (bit_tick)
  );

endmodule

`default_nettype wire

//--- design/hex_dump_fsm.sv
`timescale 1ns/1ns
`default_nettype none
`include "usb_demo_defs.svh"

module hex_dump_fsm (
  input  wire                       clock,
  input  wire                       usb_reset,
  input  wire                       send_n_i,
  input  usb_demo_pkg::telemetry_t  telemetry_i,
  output logic                      char_valid_o,
  output usb_demo_pkg::byte_t       char_data_o,
  input  wire                       char_ready_i,
  output logic                      dump_busy_o
);

  usb_demo_pkg::dump_state_t state_q;
  usb_demo_pkg::telemetry_t word_q;
  usb_demo_pkg::nibble_t nibble;
  logic [2:0] digit_q;  // 7 is the top nibble
  logic send_q;
  logic sent;

  assign dump_busy_o = (state_q != usb_demo_pkg::IDLE);
  assign nibble      = word_q[{digit_q, 2'b00} +: 4];
  assign sent        = char_valid_o && char_ready_i;

  // Character for the current state
  always_comb begin
    char_valid_o = 1'b0;
    char_data_o  = 8'h00;
    case (state_q)
      usb_demo_pkg::DIGIT: begin
        char_valid_o = 1'b1;
        if (nibble < 4'd10) begin
          char_data_o = 8'h30 + {4'h0, nibble};  // '0' to '9'
        end else begin
          char_data_o = 8'h57 + {4'h0, nibble};  // 'a' to 'f'
        end
      end
      usb_demo_pkg::TERM_CR: begin
        char_valid_o = 1'b1;
        char_data_o  = `CHAR_CR;
      end
      usb_demo_pkg::TERM_LF: begin
        char_valid_o = 1'b1;
        char_data_o  = `CHAR_LF;
      end
      default: begin
        char_valid_o = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (state_q == usb_demo_pkg::LOAD) begin
      word_q <= telemetry_i;  // Snapshot for the whole dump
    end
  end

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      send_q  <= 1'b0;
      digit_q <= '0;
      state_q <= usb_demo_pkg::IDLE;
    end else begin
      send_q <= ~send_n_i;  // Button is active low
      case (state_q)
        usb_demo_pkg::IDLE: begin
          if (send_q) begin
            state_q <= usb_demo_pkg::LOAD;
          end
        end
        usb_demo_pkg::LOAD: begin
          digit_q <= 3'd7;
          state_q <= usb_demo_pkg::DIGIT;
        end
        usb_demo_pkg::DIGIT: begin
          if (sent) begin
            digit_q <= digit_q - 3'd1;
            if (digit_q == 3'd0) begin
              state_q <= usb_demo_pkg::TERM_CR;
            end
          end
        end
        usb_demo_pkg::TERM_CR: begin
          if (sent) state_q <= usb_demo_pkg::TERM_LF;
        end
        usb_demo_pkg::TERM_LF: begin
          if (sent) state_q <= usb_demo_pkg::WAIT_TX;
        end
        usb_demo_pkg::WAIT_TX: begin
          // LF still on the line until the transmitter is idle again
          if (char_ready_i) begin
            state_q <= usb_demo_pkg::IDLE;
          end
        end
        default: state_q <= usb_demo_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
  input  wire                  clock,
  input  wire                  usb_reset,
  input  wire                  char_valid_i,
  input  usb_demo_pkg::byte_t  char_data_i,
  output logic                 char_ready_o,
  input  wire                  bit_tick_i,
  output logic                 timer_start_o,
  output logic                 txd_o
);

  logic [9:0] shift_q;      // Bit 0 drives the line
  logic [3:0] bits_left_q;
  logic busy_q;
  logic load;

  assign char_ready_o  = !busy_q;
  assign load          = char_valid_i && char_ready_o;
  assign timer_start_o = load;  // Bit period starts with the start bit
  assign txd_o         = shift_q[0];

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      shift_q     <= '1;  // Line idles high
      bits_left_q <= '0;
      busy_q      <= 1'b0;
    end else if (load) begin
      // Stop bit, data LSB first, start bit
      shift_q     <= {1'b1, char_data_i, 1'b0};
      bits_left_q <= 4'd10;
      busy_q      <= 1'b1;
    end else if (busy_q && bit_tick_i) begin
      shift_q     <= {1'b1, shift_q[9:1]};
      bits_left_q <= bits_left_q - 4'd1;
      if (bits_left_q == 4'd1) begin
        busy_q <= 1'b0;  // End of stop bit
      end
    end
  end

endmodule

`default_nettype wire

//--- design/uart_bit_timer.sv
`timescale 1ns/1ns
`default_nettype none
`include "usb_demo_defs.svh"

module uart_bit_timer (
  input  wire  clock,
  input  wire  usb_reset,
  input  wire  start_i,
  output logic tick_o
);

  logic [15:0] count_q;
  logic running_q;  // Stays low until the first start

  assign tick_o = running_q && (count_q == '0);

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      running_q <= 1'b0;
      count_q   <= '0;
    end else if (start_i) begin
      running_q <= 1'b1;
      count_q   <= 16'(`UART_CLKS_PER_BIT - 1);
    end else if (running_q) begin
      if (count_q == '0) begin
        count_q <= 16'(`UART_CLKS_PER_BIT - 1);  // Free-running reload
      end else begin
        count_q <= count_q - 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/bulk_loopback_fifo.sv
`timescale 1ns/1ns
`default_nettype none
`include "usb_demo_defs.svh"

module bulk_loopback_fifo (
  input  wire                   clock,
  input  wire                   usb_reset,
  input  wire                   configured_i,
  input  wire                   blk_store_i,
  input  wire                   blk_fetch_i,
  input  usb_demo_pkg::endpt_t  blk_endpt_i,
  input  wire                   out_valid_i,
  input  wire                   out_last_i,
  input  usb_demo_pkg::byte_t   out_data_i,
  output logic                  out_ready_o,
  output logic                  in_valid_o,
  output logic                  in_last_o,
  output usb_demo_pkg::byte_t   in_data_o,
  input  wire                   in_ready_i,
  output logic                  blk_in_ready_o,
  output logic                  blk_out_ready_o
);

  logic [8:0] mem [`BULK_FIFO_DEPTH];  // {last, data}
  logic [5:0] wr_ptr_q;
  logic [5:0] rd_ptr_q;
  usb_demo_pkg::level_t level_q;      // Memory plus output stage
  usb_demo_pkg::level_t mem_used;
  logic [8:0] stage_q;
  logic stage_valid_q;
  logic ep_match;
  logic push;
  logic pop;
  logic stage_load;

  assign ep_match = (blk_endpt_i == `BULK_ENDPOINT);

  assign out_ready_o = blk_store_i && ep_match &&
                       (level_q != usb_demo_pkg::level_t'(`BULK_FIFO_DEPTH));
  assign in_valid_o  = stage_valid_q && blk_fetch_i && ep_match;
  assign in_last_o   = stage_q[8];
  assign in_data_o   = stage_q[7:0];

  assign push = out_valid_i && out_ready_o;
  assign pop  = in_valid_o && in_ready_i;

  // Bytes still sitting in the memory, not yet in the output stage
  assign mem_used   = level_q - usb_demo_pkg::level_t'(stage_valid_q);
  assign stage_load = (mem_used != '0) && (!stage_valid_q || pop);

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr_q] <= {out_last_i, out_data_i};
    end
    if (stage_load) begin
      stage_q <= mem[rd_ptr_q];  // Second cycle of the two-cycle latency
    end
  end

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      level_q       <= '0;
      stage_valid_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 6'd1;
      end
      if (stage_load) begin
        rd_ptr_q <= rd_ptr_q + 6'd1;
      end

      if (stage_load) begin
        stage_valid_q <= 1'b1;
      end else if (pop) begin
        stage_valid_q <= 1'b0;
      end

      case ({push, pop})
        2'b10:   level_q <= level_q + 7'd1;
        2'b01:   level_q <= level_q - 7'd1;
        default: level_q <= level_q;
      endcase
    end
  end

  // Endpoint status for the core, one cycle behind the level
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      blk_in_ready_o  <= 1'b0;
      blk_out_ready_o <= 1'b0;
    end else begin
      blk_in_ready_o  <= configured_i && (level_q > `IN_READY_LEVEL);
      blk_out_ready_o <= configured_i && (level_q < `OUT_READY_LEVEL);
    end
  end

endmodule

`default_nettype wire

//--- design/usb_demo_pkg.sv
`default_nettype none

package usb_demo_pkg;

  typedef logic [7:0] byte_t;       // Stream data byte
  typedef logic [3:0] endpt_t;      // USB endpoint number
  typedef logic [6:0] level_t;      // FIFO fill level, 0 to 64
  typedef logic [31:0] telemetry_t; // Core status word, byte 3 on top
  typedef logic [3:0] nibble_t;     // One hex digit

  // Telemetry dump sequencer
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    DIGIT,
    TERM_CR,
    TERM_LF,
    WAIT_TX
  } dump_state_t;

endpackage

`default_nettype wire

//--- design/usb_demo_defs.svh
`ifndef USB_DEMO_DEFS_SVH
`define USB_DEMO_DEFS_SVH

// Bulk endpoint served by the loopback FIFO
`define BULK_ENDPOINT 4'd1

// Loopback FIFO size, 6 address bits and a 7-bit level
`define BULK_FIFO_DEPTH 64

// Endpoint status thresholds on the FIFO level
`define IN_READY_LEVEL 7'd4    // IN ready above this
`define OUT_READY_LEVEL 7'd48  // OUT ready below this

// Clocks per UART bit
// Much shorter than the board value of 33 x 8 so that simulation stays fast
`define UART_CLKS_PER_BIT 16

// Line terminator
`define CHAR_CR 8'h0d
`define CHAR_LF 8'h0a

`endif
